// File: common/div_op_pkg.sv
package div_op_pkg;

    // ========================================
    // M-extension divide opcodes
    // ========================================

    typedef enum logic [1:0] {
        OP_DIV  = 2'b00,  // signed quotient, rounded toward zero.
        OP_DIVU = 2'b01,  // unsigned quotient of both operands.
        OP_REM  = 2'b10,  // signed remainder, sign of dividend.
        OP_REMU = 2'b11   // unsigned remainder of both operands.
    } div_op_e;

    // operands taken as two's complement.
    function automatic logic is_signed_op(div_op_e op);
        return (op == OP_DIV) || (op == OP_REM);
    endfunction

    // result is the remainder, not the quotient.
    function automatic logic is_rem_op(div_op_e op);
        return (op == OP_REM) || (op == OP_REMU);
    endfunction

endpackage

// File: common/div_core_pkg.sv
package div_core_pkg;

    // iterative divide engine states.
    typedef enum logic [1:0] {
        ST_IDLE,
        ST_DIVIDE,
        ST_END,
        ST_END_ERROR
    } div_core_state_e;

endpackage

// File: hdl/div_request_fifo.sv
`timescale 1ns/100ps

module div_request_fifo import div_op_pkg::*; #(
    parameter int XLEN       = 32,
    parameter int FIFO_DEPTH = 4
) (
    input  logic            clk,
    input  logic            rst_n,
    input  logic            push,
    input  div_op_e         push_op,
    input  logic [XLEN-1:0] push_a,
    input  logic [XLEN-1:0] push_b,
    input  logic            pop,
    output logic            full,
    output logic            empty,
    output div_op_e         head_op,
    output logic [XLEN-1:0] head_a,
    output logic [XLEN-1:0] head_b
);

    localparam int PTR_W = $clog2(FIFO_DEPTH);

    div_op_e         mem_op [0:FIFO_DEPTH-1];
    logic [XLEN-1:0] mem_a  [0:FIFO_DEPTH-1];
    logic [XLEN-1:0] mem_b  [0:FIFO_DEPTH-1];

    logic [PTR_W-1:0] wr_ptr;
    logic [PTR_W-1:0] rd_ptr;
    logic [PTR_W:0]   count;
    logic             do_push;
    logic             do_pop;

    assign full    = (count == FIFO_DEPTH);
    assign empty   = (count == 0);
    assign do_push = push && !full;   // strobe while full is lost.
    assign do_pop  = pop && !empty;

    // head entry, combinational.
    assign head_op = mem_op[rd_ptr];
    assign head_a  = mem_a[rd_ptr];
    assign head_b  = mem_b[rd_ptr];

    always_ff @(posedge clk or negedge rst_n) begin
        if (!rst_n) begin
            wr_ptr <= '0;
            rd_ptr <= '0;
            count  <= '0;
        end else begin
            if (do_push)
                wr_ptr <= wr_ptr + 1'b1;  // wraps, depth is a power of two.
            if (do_pop)
                rd_ptr <= rd_ptr + 1'b1;
            case ({do_push, do_pop})
                2'b10:   count <= count + 1'b1;
                2'b01:   count <= count - 1'b1;
                default: count <= count;
            endcase
        end
    end

    always_ff @(posedge clk) begin
        if (do_push) begin
            mem_op[wr_ptr] <= push_op;
            mem_a[wr_ptr]  <= push_a;
            mem_b[wr_ptr]  <= push_b;
        end
    end

endmodule

// File: divider/div_operand_prep.sv
`timescale 1ns/100ps

module div_operand_prep import div_op_pkg::*; #(
    parameter int XLEN = 32
) (
    input  logic            clk,
    input  logic            rst_n,
    input  logic            q_empty,
    input  div_op_e         q_op,
    input  logic [XLEN-1:0] q_a,
    input  logic [XLEN-1:0] q_b,
    input  logic            core_ready,
    output logic            q_pop,
    output logic            core_start,
    output logic [XLEN-1:0] core_dividend,
    output logic [XLEN-1:0] core_divisor,
    output div_op_e         op_hold,
    output logic            neg_quot,
    output logic            neg_rem
);

    logic op_signed;
    logic a_neg;
    logic b_neg;

    assign op_signed = is_signed_op(q_op);
    assign a_neg     = op_signed && q_a[XLEN-1];
    assign b_neg     = op_signed && q_b[XLEN-1];

    // ========================================
    // issue to the engine
    // ========================================

    assign core_start = core_ready && !q_empty;
    assign q_pop      = core_start;   // one request in flight at a time.

    // magnitudes; most negative value maps onto itself, read as unsigned.
    assign core_dividend = a_neg ? -q_a : q_a;
    assign core_divisor  = b_neg ? -q_b : q_b;

    // sign and opcode held until the engine answers.
    always_ff @(posedge clk or negedge rst_n) begin
        if (!rst_n) begin
            op_hold  <= OP_DIVU;
            neg_quot <= 1'b0;
            neg_rem  <= 1'b0;
        end else if (core_start) begin
            op_hold  <= q_op;
            neg_quot <= a_neg ^ b_neg;
            neg_rem  <= a_neg;   // remainder follows the dividend.
        end
    end

endmodule

// File: divider/div_unsigned_core.sv
`timescale 1ns/100ps

module div_unsigned_core import div_core_pkg::*; #(
    parameter int XLEN = 32
) (
    input  logic            clk,
    input  logic            rst_n,
    input  logic            start,
    input  logic [XLEN-1:0] dividend,
    input  logic [XLEN-1:0] divisor,
    output logic            ready,
    output logic            valid,
    output logic            error,
    output logic [XLEN-1:0] quotient,
    output logic [XLEN-1:0] remainder
);

    div_core_state_e state;

    logic [XLEN-1:0]   count;             // one-hot, current quotient bit.
    logic [2*XLEN-1:0] shifted_divisor;
    logic              can_sub;

    assign ready = (state == ST_IDLE);
    assign valid = (state == ST_END) || (state == ST_END_ERROR);
    assign error = (state == ST_END_ERROR);

    // full-width compare, upper divisor bits must not be dropped.
    assign can_sub = ({{XLEN{1'b0}}, remainder} >= shifted_divisor);

    // ========================================
    // control
    // ========================================

    always_ff @(posedge clk or negedge rst_n) begin
        if (!rst_n) begin
            state <= ST_IDLE;
        end else begin
            case (state)
                ST_IDLE: begin
                    if (start) begin
                        if (divisor == '0)
                            state <= ST_END_ERROR;
                        else if (divisor > dividend)
                            state <= ST_END;   // fast path, quotient zero.
                        else
                            state <= ST_DIVIDE;
                    end
                end
                ST_DIVIDE: begin
                    if (count[0])
                        state <= ST_END;   // last quotient bit done.
                end
                default: state <= ST_IDLE;
            endcase
        end
    end

    // ========================================
    // datapath
    // ========================================

    always_ff @(posedge clk) begin
        case (state)
            ST_IDLE: begin
                if (start) begin
                    remainder       <= dividend;
                    quotient        <= (divisor == '0) ? '1 : '0;
                    shifted_divisor <= {1'b0, divisor, {(XLEN-1){1'b0}}};
                    count           <= {1'b1, {(XLEN-1){1'b0}}};
                end
            end
            ST_DIVIDE: begin
                if (can_sub) begin
                    remainder <= remainder - shifted_divisor[XLEN-1:0];
                    quotient  <= quotient | count;
                end
                shifted_divisor <= shifted_divisor >> 1;
                count           <= count >> 1;
            end
            default: begin
                count <= count;
            end
        endcase
    end

endmodule

// File: divider/div_result_fixup.sv
`timescale 1ns/100ps

module div_result_fixup import div_op_pkg::*; #(
    parameter int XLEN = 32
) (
    input  logic            clk,
    input  logic            rst_n,
    input  logic            core_valid,
    input  logic            core_error,
    input  logic [XLEN-1:0] core_quotient,
    input  logic [XLEN-1:0] core_remainder,
    input  div_op_e         op_hold,
    input  logic            neg_quot,
    input  logic            neg_rem,
    output logic            resp_valid,
    output logic [XLEN-1:0] resp_data,
    output logic            resp_div_zero
);

    logic [XLEN-1:0] quot_fix;
    logic [XLEN-1:0] rem_fix;
    logic [XLEN-1:0] result;

    // divide by zero keeps the all-ones quotient unsigned.
    assign quot_fix = (neg_quot && !core_error) ? -core_quotient : core_quotient;

    // restores the original dividend on divide by zero too.
    assign rem_fix = neg_rem ? -core_remainder : core_remainder;

    assign result = is_rem_op(op_hold) ? rem_fix : quot_fix;

    // ========================================
    // response register
    // ========================================

    always_ff @(posedge clk or negedge rst_n) begin
        if (!rst_n)
            resp_valid <= 1'b0;
        else
            resp_valid <= core_valid;   // one strobe per engine result.
    end

    always_ff @(posedge clk) begin
        if (core_valid) begin
            resp_data     <= result;
            resp_div_zero <= core_error;
        end
    end

endmodule

// File: hdl/div_unit_top.sv
`timescale 1ns/100ps

module div_unit_top import div_op_pkg::*; #(
    parameter int XLEN       = 32,
    parameter int FIFO_DEPTH = 4
) (
    input  logic            clk,
    input  logic            rst_n,
    input  logic            req_valid,
    input  div_op_e         req_op,
    input  logic [XLEN-1:0] req_a,
    input  logic [XLEN-1:0] req_b,
    output logic            req_full,
    output logic            resp_valid,
    output logic [XLEN-1:0] resp_data,
    output logic            resp_div_zero
);

    // queue head.
    logic            q_empty;
    logic            q_pop;
    div_op_e         q_op;
    logic [XLEN-1:0] q_a;
    logic [XLEN-1:0] q_b;

    // engine.
    logic            core_start;
    logic            core_ready;
    logic            core_valid;
    logic            core_error;
    logic [XLEN-1:0] core_dividend;
    logic [XLEN-1:0] core_divisor;
    logic [XLEN-1:0] core_quotient;
    logic [XLEN-1:0] core_remainder;

    // held request info.
    div_op_e         op_hold;
    logic            neg_quot;
    logic            neg_rem;

    div_request_fifo #(
        .XLEN       (XLEN),
        .FIFO_DEPTH (FIFO_DEPTH)
    ) div_request_fifo_inst (
        .clk     (clk),
        .rst_n   (rst_n),
        .push    (req_valid),
        .push_op (req_op),
        .push_a  (req_a),
        .push_b  (req_b),
        .pop     (q_pop),
        .full    (req_full),
        .empty   (q_empty),
        .head_op (q_op),
        .head_a  (q_a),
        .head_b  (q_b)
    );

    div_operand_prep #(
        .XLEN (XLEN)
    ) div_operand_prep_inst (
        .clk           (clk),
        .rst_n         (rst_n),
        .q_empty       (q_empty),
        .q_op          (q_op),
        .q_a           (q_a),
        .q_b           (q_b),
        .core_ready    (core_ready),
        .q_pop         (q_pop),
        .core_start    (core_start),
        .core_dividend (core_dividend),
        .core_divisor  (core_divisor),
        .op_hold       (op_hold),
        .neg_quot      (neg_quot),
        .neg_rem       (neg_rem)
    );

    div_unsigned_core #(
        .XLEN (XLEN)
    ) div_unsigned_core_inst (
        .clk       (clk),
        .rst_n     (rst_n),
        .start     (core_start),
        .dividend  (core_dividend),
        .divisor   (core_divisor),
        .ready     (core_ready),
        .valid     (core_valid),
        .error     (core_error),
        .quotient  (core_quotient),
        .remainder (core_remainder)
    );

    div_result_fixup #(
        .XLEN (XLEN)
    ) div_result_fixup_inst (
        .clk            (clk),
        .rst_n          (rst_n),
        .core_valid     (core_valid),
        .core_error     (core_error),
        .core_quotient  (core_quotient),
        .core_remainder (core_remainder),
        .op_hold        (op_hold),
        .neg_quot       (neg_quot),
        .neg_rem        (neg_rem),
        .resp_valid     (resp_valid),
        .resp_data      (resp_data),
        .resp_div_zero  (resp_div_zero)
    );

endmodule

// File: tb/div_unit_sva.sv
`timescale 1ns/100ps

module div_unit_sva import div_core_pkg::*; (
    input logic            clk,
    input logic            rst_n,
    input logic            req_valid,
    input logic            req_full,
    input logic            resp_valid,
    input logic            core_start,
    input logic            core_valid,
    input div_core_state_e core_state
);

    logic in_flight;   // engine holds a request.

    always_ff @(posedge clk or negedge rst_n) begin
        if (!rst_n)
            in_flight <= 1'b0;
        else if (core_start)
            in_flight <= 1'b1;
        else if (core_valid)
            in_flight <= 1'b0;
    end

    // ========================================
    // port and engine protocol
    // ========================================

    resp_single_beat: assert property (@(posedge clk) disable iff (!rst_n)
        resp_valid |=> !resp_valid)
        else $error("resp_valid high on two consecutive cycles");

    no_push_when_full: assert property (@(posedge clk) disable iff (!rst_n)
        !(req_valid && req_full))
        else $error("request strobe while the queue is full");

    start_needs_ready: assert property (@(posedge clk) disable iff (!rst_n)
        core_start |-> !in_flight)
        else $error("engine started while busy");

    idle_after_valid: assert property (@(posedge clk) disable iff (!rst_n)
        core_valid |=> (core_state == ST_IDLE))
        else $error("engine not idle one cycle after valid");

endmodule

bind div_unit_top div_unit_sva div_unit_sva_inst (
    .clk        (clk),
    .rst_n      (rst_n),
    .req_valid  (req_valid),
    .req_full   (req_full),
    .resp_valid (resp_valid),
    .core_start (core_start),
    .core_valid (core_valid),
    .core_state (div_unsigned_core_inst.state)
);

// File: tb/div_unit_tb.sv
`timescale 1ns/100ps

module div_unit_tb import div_op_pkg::*; ();

    localparam int XLEN            = 32;
    localparam int FIFO_DEPTH      = 4;
    localparam int CLK_PERIOD      = 8;
    localparam int NUM_REQS        = 36;
    localparam int WATCHDOG_CYCLES = NUM_REQS * (XLEN + 8) + 200;

    logic            clk = 1'b0;
    logic            rst_n;
    logic            req_valid;
    div_op_e         req_op;
    logic [XLEN-1:0] req_a;
    logic [XLEN-1:0] req_b;
    logic            req_full;
    logic            resp_valid;
    logic [XLEN-1:0] resp_data;
    logic            resp_div_zero;

    logic [XLEN-1:0] exp_data [$];
    logic            exp_zero [$];
    string           exp_desc [$];
    int              errors;
    logic            saw_full;
    integer          seed;

    always #(CLK_PERIOD / 2) clk = ~clk;

    div_unit_top #(
        .XLEN       (XLEN),
        .FIFO_DEPTH (FIFO_DEPTH)
    ) div_unit_top_inst (
        .clk           (clk),
        .rst_n         (rst_n),
        .req_valid     (req_valid),
        .req_op        (req_op),
        .req_a         (req_a),
        .req_b         (req_b),
        .req_full      (req_full),
        .resp_valid    (resp_valid),
        .resp_data     (resp_data),
        .resp_div_zero (resp_div_zero)
    );

    // ========================================
    // reference model and checker
    // ========================================

    function automatic logic [XLEN-1:0] expected_result(div_op_e op, logic [XLEN-1:0] a,
                                                        logic [XLEN-1:0] b);
        logic want_rem;
        logic signed_op;
        want_rem  = (op == OP_REM) || (op == OP_REMU);
        signed_op = (op == OP_DIV) || (op == OP_REM);
        if (b == '0)
            return want_rem ? a : '1;   // riscv divide by zero.
        if (signed_op && a == {1'b1, {(XLEN-1){1'b0}}} && b == '1)
            return want_rem ? '0 : a;   // signed overflow.
        if (signed_op)
            return want_rem ? $signed(a) % $signed(b) : $signed(a) / $signed(b);
        return want_rem ? a % b : a / b;
    endfunction

    task automatic check_value(input string what, input logic [XLEN-1:0] got,
                               input logic [XLEN-1:0] exp);
        if (got !== exp) begin
            errors++;
            $display("ERROR %0t: %s got %h expected %h", $time, what, got, exp);
        end
    endtask

    // outputs settle after the edge, sampled on the falling edge.
    always @(negedge clk) begin
        if (rst_n && resp_valid) begin
            if (exp_data.size() == 0) begin
                errors++;
                $display("Response at %0t arrived with no request pending", $time);
            end else begin
                check_value({exp_desc[0], " data"}, resp_data, exp_data[0]);
                check_value({exp_desc[0], " div_zero"}, {{(XLEN-1){1'b0}}, resp_div_zero},
                            {{(XLEN-1){1'b0}}, exp_zero[0]});
                void'(exp_data.pop_front());
                void'(exp_zero.pop_front());
                void'(exp_desc.pop_front());
            end
        end
    end

    // ========================================
    // stimulus
    // ========================================

    task automatic issue_req(input div_op_e op, input logic [XLEN-1:0] a,
                             input logic [XLEN-1:0] b);
        while (req_full) begin
            saw_full = 1'b1;
            @(posedge clk);
            #1;
        end
        req_valid = 1'b1;
        req_op    = op;
        req_a     = a;
        req_b     = b;
        exp_data.push_back(expected_result(op, a, b));
        exp_zero.push_back(b == '0);
        exp_desc.push_back($sformatf("%s %h/%h", op.name(), a, b));
        @(posedge clk);
        #1;
        req_valid = 1'b0;
    endtask

    task automatic wait_drain();
        int limit;
        int n;
        limit = (exp_data.size() + 1) * (XLEN + 8);
        n     = 0;
        while (exp_data.size() != 0 && n < limit) begin
            @(posedge clk);
            #1;
            n++;
        end
    endtask

    task automatic test_unsigned();
        issue_req(OP_DIVU, 32'd100, 32'd7);
        issue_req(OP_REMU, 32'd100, 32'd7);
        issue_req(OP_DIVU, 32'd5, 32'd9);      // dividend below divisor.
        issue_req(OP_REMU, 32'd5, 32'd9);
        issue_req(OP_DIVU, 32'd12345, 32'd12345);
        issue_req(OP_REMU, 32'd12345, 32'd12345);
        issue_req(OP_DIVU, 32'hffff_ffff, 32'd3);
        issue_req(OP_REMU, 32'hffff_ffff, 32'd10);
        wait_drain();
    endtask

    task automatic test_signed();
        logic [XLEN-1:0] a;
        logic [XLEN-1:0] b;
        for (int i = 0; i < 4; i++) begin
            a = (i & 1) ? -32'd100 : 32'd100;
            b = (i & 2) ? -32'd7 : 32'd7;
            issue_req(OP_DIV, a, b);
            issue_req(OP_REM, a, b);
        end
        wait_drain();
    endtask

    task automatic test_div_zero();
        issue_req(OP_DIV, -32'd12345, 32'd0);
        issue_req(OP_DIVU, -32'd12345, 32'd0);
        issue_req(OP_REM, -32'd12345, 32'd0);
        issue_req(OP_REMU, -32'd12345, 32'd0);
        wait_drain();
    endtask

    task automatic test_overflow();
        issue_req(OP_DIV, 32'h8000_0000, 32'hffff_ffff);
        issue_req(OP_REM, 32'h8000_0000, 32'hffff_ffff);
        issue_req(OP_DIVU, 32'h8000_0000, 32'hffff_ffff);
        issue_req(OP_REMU, 32'h8000_0000, 32'hffff_ffff);
        wait_drain();
    endtask

    task automatic test_burst();
        logic [XLEN-1:0] a;
        logic [XLEN-1:0] b;
        logic [XLEN-1:0] r;
        div_op_e         op;
        saw_full = 1'b0;
        for (int i = 0; i < 12; i++) begin
            r  = $random(seed);
            op = div_op_e'(r[1:0]);
            a  = $random(seed);
            r  = $random(seed);
            // small divisors keep most requests on the long path.
            if (op == OP_DIV || op == OP_REM)
                b = {{(XLEN-12){r[11]}}, r[11:0]};
            else
                b = {{(XLEN-12){1'b0}}, r[11:0]};
            issue_req(op, a, b);
        end
        wait_drain();
        if (!saw_full) begin
            errors++;
            $display("req_full was never seen high during the burst");
        end
    endtask

    // ========================================
    // main sequence and watchdog
    // ========================================

    initial begin
        seed      = 32'h8b6e;
        errors    = 0;
        saw_full  = 1'b0;
        rst_n     = 1'b0;
        req_valid = 1'b0;
        req_op    = OP_DIV;
        req_a     = '0;
        req_b     = '0;
        repeat (5) @(posedge clk);
        #1;
        rst_n = 1'b1;
        test_unsigned();
        test_signed();
        test_div_zero();
        test_overflow();
        test_burst();
        if (exp_data.size() != 0) begin
            errors++;
            $display("%0d expected responses never arrived", exp_data.size());
        end
        $display("Errors: %0d", errors);
        if (errors == 0)
            $display("TEST OK");
        else
            $display("TEST FAILED");
        $finish;
    end

    initial begin
        #(WATCHDOG_CYCLES * CLK_PERIOD);
        $display("Timeout: the tests did not finish in the expected time");
        $display("TEST FAILED");
        $finish;
    end

endmodule

// File: div_unit.f
common/div_op_pkg.sv
common/div_core_pkg.sv
hdl/div_request_fifo.sv
divider/div_operand_prep.sv
divider/div_unsigned_core.sv
divider/div_result_fixup.sv
hdl/div_unit_top.sv
tb/div_unit_sva.sv
tb/div_unit_tb.sv

// File: run_sim.sh
#!/bin/bash
# Build and run the divide unit testbench with Verilator.
cd "$(dirname "$0")" || exit 1
rm -rf obj_dir sim.log

verilator --binary --timing --assert -Wno-fatal -f div_unit.f \
    --top-module div_unit_tb -o div_unit_sim \
    && ./obj_dir/div_unit_sim 2>&1 | tee sim.log \
    && grep -q "^TEST OK$" sim.log \
    && echo "simulation passed" \
    || { echo "simulation failed"; exit 1; }
